/* stream_pkg.sv */
// ----------------------------------------
// stream widths and the beat format
// src is log2 of the default port count and
// does not follow a top-level override, so
// keep NUM_PORTS a power of two up to 4
// ----------------------------------------

package stream_pkg;

    // default port count for the top level
    localparam int NUM_PORTS = 4;

    localparam int DATA_W = 16;
    localparam int SRC_W  = $clog2(NUM_PORTS);

    typedef logic [DATA_W-1:0] data_t;

    // index of the input a beat came from
    typedef logic [SRC_W-1:0] src_t;

    // one stream beat, 19 bits with the defaults
    typedef struct packed {
        data_t data;
        logic  last;
        src_t  src;
    } beat_t;

endpackage

/* regs_pkg.sv */
// ----------------------------------------
// APB request format and register map
// byte addresses, 32-bit data, no wait
// states and no error responses
// ----------------------------------------

package regs_pkg;

    typedef logic [7:0]  paddr_t;
    typedef logic [31:0] pdata_t;

    // master side of the bus, 43 bits
    typedef struct packed {
        logic   psel;
        logic   penable;
        logic   pwrite;
        paddr_t paddr;
        pdata_t pwdata;
    } apb_req_t;

    typedef enum logic {
        ARB_FIXED       = 1'b0,
        ARB_ROUND_ROBIN = 1'b1
    } arb_mode_t;

    // wraps at 2^16
    typedef logic [15:0] pkt_count_t;

    // control: enable mask in the low bits, mode at bit 8
    localparam paddr_t ADDR_CTRL     = 8'h00;
    localparam int     CTRL_MODE_BIT = 8;

    // read-only packet counters, one word per input
    localparam int     COUNT_STRIDE = 4;
    localparam paddr_t ADDR_COUNT0  = 8'h10;
    localparam paddr_t ADDR_COUNT1  = ADDR_COUNT0 + paddr_t'(1 * COUNT_STRIDE);
    localparam paddr_t ADDR_COUNT2  = ADDR_COUNT0 + paddr_t'(2 * COUNT_STRIDE);
    localparam paddr_t ADDR_COUNT3  = ADDR_COUNT0 + paddr_t'(3 * COUNT_STRIDE);

endpackage

/* packet_arbiter.sv */
// ----------------------------------------
// packet arbiter, one grant at a time
// the grant is registered and held until
// the acknowledge of the granted input
// round robin restarts after the last grant
// ----------------------------------------

`timescale 1ns/1ps

module packet_arbiter #(
    parameter int NUM_PORTS = 4
) (
    input  logic                clk,
    input  logic                rst,
    input  regs_pkg::arb_mode_t arb_mode,
    input  logic [NUM_PORTS-1:0] request,
    input  logic [NUM_PORTS-1:0] acknowledge,
    output logic                grant_valid,
    output stream_pkg::src_t    grant_index
);

    stream_pkg::src_t last_index;
    stream_pkg::src_t pick_index;
    logic             pick_found;

    // search for the next winner among the requests
    always_comb begin
        int unsigned search_base;
        int unsigned cand;

        search_base = 0;
        cand        = 0;
        pick_found  = 1'b0;
        pick_index  = '0;

        // fixed mode always starts at input 0
        if (arb_mode == regs_pkg::ARB_ROUND_ROBIN) begin
            search_base = int'(last_index) + 1;
        end

        for (int unsigned i = 0; i < NUM_PORTS; i++) begin
            cand = (search_base + i) % NUM_PORTS;
            if (!pick_found && request[cand]) begin
                pick_found = 1'b1;
                pick_index = stream_pkg::src_t'(cand);
            end
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            grant_valid <= 1'b0;
            grant_index <= '0;
            // so the first round robin search starts at input 0
            last_index  <= stream_pkg::src_t'(NUM_PORTS - 1);
        end else if (grant_valid) begin
            // held until the packet's last beat is accepted
            if (acknowledge[grant_index]) begin
                grant_valid <= 1'b0;
            end
        end else if (pick_found) begin
            grant_valid <= 1'b1;
            grant_index <= pick_index;
            last_index  <= pick_index;
        end
    end

endmodule

/* stream_arb_mux.sv */
// ----------------------------------------
// packet multiplexer in front of the skid
// ready goes only to the granted input and
// only while the skid's registered ready is
// high; src of the input beats is replaced
// ----------------------------------------

`timescale 1ns/1ps

module stream_arb_mux #(
    parameter int NUM_PORTS = 4
) (
    input  logic                 clk,
    input  logic                 rst,
    input  stream_pkg::beat_t    in_beat [NUM_PORTS],
    input  logic [NUM_PORTS-1:0] in_valid,
    output logic [NUM_PORTS-1:0] in_ready,
    input  logic [NUM_PORTS-1:0] port_enable,
    input  regs_pkg::arb_mode_t  arb_mode,
    output stream_pkg::beat_t    mid_beat,
    output logic                 mid_valid,
    input  logic                 mid_ready,
    output logic [NUM_PORTS-1:0] pkt_done
);

    logic [NUM_PORTS-1:0] request;
    logic                 grant_valid;
    stream_pkg::src_t     grant_index;
    stream_pkg::beat_t    cur_beat;

    // masking here leaves a granted packet running to its end
    assign request = in_valid & port_enable;

    packet_arbiter #(
        .NUM_PORTS(NUM_PORTS)
    ) packet_arbiter_inst (
        .clk        (clk),
        .rst        (rst),
        .arb_mode   (arb_mode),
        .request    (request),
        .acknowledge(pkt_done),
        .grant_valid(grant_valid),
        .grant_index(grant_index)
    );

    assign cur_beat = in_beat[grant_index];

    // stamp the source index on the way through
    always_comb begin
        mid_beat      = cur_beat;
        mid_beat.src  = grant_index;
        mid_valid     = grant_valid && in_valid[grant_index] && mid_ready;
    end

    always_comb begin
        in_ready = '0;
        in_ready[grant_index] = grant_valid && mid_ready;
    end

    // a transfer of the granted last beat ends the packet
    always_comb begin
        pkt_done = '0;
        pkt_done[grant_index] = mid_valid && cur_beat.last;
    end

endmodule

/* stream_skid_buffer.sv */
// ----------------------------------------
// registered output stage with one spare
// entry; in_ready is a flop, so it lags
// by a cycle and the spare catches the beat
// that arrives meanwhile
// ----------------------------------------

`timescale 1ns/1ps

module stream_skid_buffer (
    input  logic              clk,
    input  logic              rst,
    input  stream_pkg::beat_t in_beat,
    input  logic              in_valid,
    output logic              in_ready,
    output stream_pkg::beat_t out_beat,
    output logic              out_valid,
    input  logic              out_ready
);

    stream_pkg::beat_t temp_beat;
    logic              temp_valid;
    logic              out_valid_next;
    logic              temp_valid_next;
    logic              ready_early;

    logic load_out_from_in;
    logic load_temp_from_in;
    logic load_out_from_temp;

    // stay ready unless the spare could be filled next cycle
    assign ready_early = out_ready || (!temp_valid && (!out_valid || !in_valid));

    always_comb begin
        out_valid_next     = out_valid;
        temp_valid_next    = temp_valid;
        load_out_from_in   = 1'b0;
        load_temp_from_in  = 1'b0;
        load_out_from_temp = 1'b0;

        if (in_ready) begin
            if (out_ready || !out_valid) begin
                // output free, go straight there
                out_valid_next   = in_valid;
                load_out_from_in = 1'b1;
            end else begin
                // output stalled, park in the spare
                temp_valid_next   = in_valid;
                load_temp_from_in = 1'b1;
            end
        end else if (out_ready) begin
            // drain the spare into the output
            out_valid_next     = temp_valid;
            temp_valid_next    = 1'b0;
            load_out_from_temp = 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            out_valid  <= 1'b0;
            temp_valid <= 1'b0;
            in_ready   <= 1'b0;
        end else begin
            out_valid  <= out_valid_next;
            temp_valid <= temp_valid_next;
            in_ready   <= ready_early;
        end
    end

    // payload
    always_ff @(posedge clk) begin
        if (load_out_from_in) begin
            out_beat <= in_beat;
        end else if (load_out_from_temp) begin
            out_beat <= temp_beat;
        end

        if (load_temp_from_in) begin
            temp_beat <= in_beat;
        end
    end

endmodule

/* mux_regs.sv */
// ----------------------------------------
// APB register block for the multiplexer
// pready is tied high, pslverr is absent
// read data is driven in the access cycle
// and is zero for unmapped addresses
// NUM_PORTS must not exceed 8 (mode bit)
// ----------------------------------------

`timescale 1ns/1ps

module mux_regs #(
    parameter int NUM_PORTS = 4
) (
    input  logic                 clk,
    input  logic                 rst,
    input  regs_pkg::apb_req_t   apb_req,
    output regs_pkg::pdata_t     prdata,
    output logic                 pready,
    output logic [NUM_PORTS-1:0] port_enable,
    output regs_pkg::arb_mode_t  arb_mode,
    input  logic [NUM_PORTS-1:0] pkt_done
);

    regs_pkg::pkt_count_t pkt_count [NUM_PORTS];
    regs_pkg::pdata_t     read_word;
    logic                 access;
    logic                 ctrl_write;

    // second phase of a transfer
    assign access     = apb_req.psel && apb_req.penable;
    assign ctrl_write = access && apb_req.pwrite && (apb_req.paddr == regs_pkg::ADDR_CTRL);

    assign pready = 1'b1;

    always_ff @(posedge clk) begin
        if (rst) begin
            port_enable <= '1;
            arb_mode    <= regs_pkg::ARB_FIXED;
        end else if (ctrl_write) begin
            port_enable <= apb_req.pwdata[NUM_PORTS-1:0];
            arb_mode    <= regs_pkg::arb_mode_t'(apb_req.pwdata[regs_pkg::CTRL_MODE_BIT]);
        end
    end

    // completed packets per input
    always_ff @(posedge clk) begin
        for (int i = 0; i < NUM_PORTS; i++) begin
            if (rst) begin
                pkt_count[i] <= '0;
            end else if (pkt_done[i]) begin
                pkt_count[i] <= pkt_count[i] + 1'b1;
            end
        end
    end

    // address decode for reads
    always_comb begin
        read_word = '0;

        if (apb_req.paddr == regs_pkg::ADDR_CTRL) begin
            read_word[NUM_PORTS-1:0]          = port_enable;
            read_word[regs_pkg::CTRL_MODE_BIT] = arb_mode;
        end

        for (int i = 0; i < NUM_PORTS; i++) begin
            if (apb_req.paddr == regs_pkg::ADDR_COUNT0
                                 + regs_pkg::paddr_t'(i * regs_pkg::COUNT_STRIDE)) begin
                read_word = regs_pkg::pdata_t'(pkt_count[i]);
            end
        end
    end

    // only a read access drives the bus
    assign prdata = (access && !apb_req.pwrite) ? read_word : '0;

endmodule

/* arb_mux_top.sv */
// ----------------------------------------
// arbitrated packet multiplexer with APB
// control; the output beat's src field is
// the input index the packet came from
// latency varies, follow out_valid
// ----------------------------------------

`timescale 1ns/1ps

module arb_mux_top #(
    parameter int NUM_PORTS = stream_pkg::NUM_PORTS
) (
    input  logic                 clk,
    input  logic                 rst,
    input  regs_pkg::apb_req_t   apb_req,
    output regs_pkg::pdata_t     prdata,
    output logic                 pready,
    input  stream_pkg::beat_t    in_beat [NUM_PORTS],
    input  logic [NUM_PORTS-1:0] in_valid,
    output logic [NUM_PORTS-1:0] in_ready,
    output stream_pkg::beat_t    out_beat,
    output logic                 out_valid,
    input  logic                 out_ready
);

    logic [NUM_PORTS-1:0] port_enable;
    regs_pkg::arb_mode_t  arb_mode;
    logic [NUM_PORTS-1:0] pkt_done;

    // between the mux and the output stage
    stream_pkg::beat_t    mid_beat;
    logic                 mid_valid;
    logic                 mid_ready;

    mux_regs #(
        .NUM_PORTS(NUM_PORTS)
    ) mux_regs_inst (
        .clk        (clk),
        .rst        (rst),
        .apb_req    (apb_req),
        .prdata     (prdata),
        .pready     (pready),
        .port_enable(port_enable),
        .arb_mode   (arb_mode),
        .pkt_done   (pkt_done)
    );

    stream_arb_mux #(
        .NUM_PORTS(NUM_PORTS)
    ) stream_arb_mux_inst (
        .clk        (clk),
        .rst        (rst),
        .in_beat    (in_beat),
        .in_valid   (in_valid),
        .in_ready   (in_ready),
        .port_enable(port_enable),
        .arb_mode   (arb_mode),
        .mid_beat   (mid_beat),
        .mid_valid  (mid_valid),
        .mid_ready  (mid_ready),
        .pkt_done   (pkt_done)
    );

    stream_skid_buffer stream_skid_buffer_inst (
        .clk      (clk),
        .rst      (rst),
        .in_beat  (mid_beat),
        .in_valid (mid_valid),
        .in_ready (mid_ready),
        .out_beat (out_beat),
        .out_valid(out_valid),
        .out_ready(out_ready)
    );

endmodule

/* tb_clock_gen.sv */
// ----------------------------------------
// clock and reset for the testbench
// reset is released 2 ns after the last
// reset edge, in step with the stimulus
// ----------------------------------------

`timescale 1ns/1ps

module tb_clock_gen #(
    parameter int PERIOD_NS    = 40,
    parameter int RESET_CYCLES = 3
) (
    output logic clk,
    output logic rst
);

    initial begin
        clk = 1'b0;
        forever #(PERIOD_NS / 2) clk = ~clk;
    end

    initial begin
        rst = 1'b1;
        repeat (RESET_CYCLES) @(posedge clk);
        #2 rst = 1'b0;
    end

endmodule

/* arb_mux_assertions.sv */
// ----------------------------------------
// protocol checks bound into arb_mux_top
// APB checks assume no wait states
// ----------------------------------------

`timescale 1ns/1ps

module arb_mux_assertions #(
    parameter int NUM_PORTS = 4
) (
    input logic                 clk,
    input logic                 rst,
    input regs_pkg::apb_req_t   apb_req,
    input stream_pkg::beat_t    in_beat [NUM_PORTS],
    input logic [NUM_PORTS-1:0] in_valid,
    input logic [NUM_PORTS-1:0] in_ready,
    input stream_pkg::beat_t    out_beat,
    input logic                 out_valid,
    input logic                 out_ready
);

    logic                 pkt_open;
    logic [NUM_PORTS-1:0] open_mask;

    // input whose packet is part way through
    always_ff @(posedge clk) begin
        if (rst) begin
            pkt_open  <= 1'b0;
            open_mask <= '0;
        end else begin
            for (int i = 0; i < NUM_PORTS; i++) begin
                if (in_ready[i] && in_valid[i]) begin
                    pkt_open  <= !in_beat[i].last;
                    open_mask <= in_ready & in_valid;
                end
            end
        end
    end

    // a stalled output keeps its beat
    out_hold: assert property (@(posedge clk) disable iff (rst)
        (out_valid && !out_ready) |=> (out_valid && $stable(out_beat)))
        else $error("out_beat changed or out_valid dropped while stalled");

    // one ready at a time, and none to another input inside a packet
    ready_onehot: assert property (@(posedge clk) disable iff (rst)
        $onehot0(in_ready) && (!pkt_open || (in_ready & ~open_mask) == '0))
        else $error("in_ready given to a second input or in the middle of a packet");

    apb_access_order: assert property (@(posedge clk) disable iff (rst)
        (apb_req.psel && apb_req.penable) |-> $past(apb_req.psel && !apb_req.penable))
        else $error("APB access cycle without a setup cycle before it");

endmodule

bind arb_mux_top arb_mux_assertions #(
    .NUM_PORTS(NUM_PORTS)
) arb_mux_assertions_inst (
    .clk      (clk),
    .rst      (rst),
    .apb_req  (apb_req),
    .in_beat  (in_beat),
    .in_valid (in_valid),
    .in_ready (in_ready),
    .out_beat (out_beat),
    .out_valid(out_valid),
    .out_ready(out_ready)
);

/* arb_mux_tb.sv */
// ----------------------------------------
// testbench for arb_mux_top
// random packet sources and a random sink;
// one queue model per source, output beats
// are matched through their src field
// ----------------------------------------

`timescale 1ns/1ps

module arb_mux_tb;

    localparam int NUM_PORTS   = stream_pkg::NUM_PORTS;
    localparam int DRIVE_DELAY = 2;
    localparam int RAND_SEED   = 32'h4ef3cf0a;
    localparam int RANDOM_PKTS = 20;
    localparam int MASK_PKTS   = 6;
    localparam int RR_PKTS     = 4;
    localparam int MAX_PKT_LEN = 8;
    // every packet at full length, 40 cycles per beat
    localparam int TOTAL_BEATS =
        MAX_PKT_LEN * (NUM_PORTS * (RANDOM_PKTS + MASK_PKTS + RR_PKTS) + 2);
    localparam int TIMEOUT_CYCLES = TOTAL_BEATS * 40 + 2000;

    logic                 clk;
    logic                 rst;
    regs_pkg::apb_req_t   apb_req;
    regs_pkg::pdata_t     prdata;
    logic                 pready;
    stream_pkg::beat_t    in_beat [NUM_PORTS];
    logic [NUM_PORTS-1:0] in_valid;
    logic [NUM_PORTS-1:0] in_ready;
    stream_pkg::beat_t    out_beat;
    logic                 out_valid;
    logic                 out_ready;

    // model
    stream_pkg::beat_t src_q [NUM_PORTS][$];
    int                pkt_target [NUM_PORTS];
    int                done_count [NUM_PORTS];
    stream_pkg::src_t  start_log [$];
    stream_pkg::src_t  cur_src;
    logic              in_pkt;

    string test_name;
    int    gap_max;
    int    error_count;
    logic  sink_stall;
    logic  forbid2;

    tb_clock_gen tb_clock_gen_inst (.clk(clk), .rst(rst));

    arb_mux_top #(
        .NUM_PORTS(NUM_PORTS)
    ) arb_mux_top_inst (.*);

    // one packet source per input
    for (genvar g = 0; g < NUM_PORTS; g++) begin : source_gen
        stream_pkg::beat_t beat_q;
        logic              valid_q;
        int                sent;

        assign in_beat[g]  = beat_q;
        assign in_valid[g] = valid_q;

        initial begin
            int                len;
            int                gap;
            stream_pkg::beat_t model_beat;
            beat_q  = '0;
            valid_q = 1'b0;
            sent    = 0;
            wait (rst === 1'b0);
            forever begin
                wait (sent < pkt_target[g]);
                sent++;
                len = 1 + int'($urandom % MAX_PKT_LEN);
                gap = int'($urandom % (gap_max + 1));
                repeat (gap + 1) begin
                    @(posedge clk);
                    #DRIVE_DELAY;
                end
                for (int i = 0; i < len; i++) begin
                    // src is ignored on the input side
                    beat_q.data = stream_pkg::data_t'($urandom);
                    beat_q.last = (i == len - 1);
                    beat_q.src  = stream_pkg::src_t'($urandom);
                    valid_q     = 1'b1;
                    model_beat     = beat_q;
                    model_beat.src = stream_pkg::src_t'(g);
                    src_q[g].push_back(model_beat);
                    // ready seen at the falling edge means a transfer at the next rise
                    do begin
                        @(negedge clk);
                    end while (!in_ready[g]);
                    @(posedge clk);
                    #DRIVE_DELAY;
                end
                valid_q = 1'b0;
            end
        end
    end

    // random sink
    initial begin
        out_ready = 1'b0;
        wait (rst === 1'b0);
        forever begin
            @(posedge clk);
            #DRIVE_DELAY;
            out_ready = sink_stall ? 1'b0 : (($urandom % 4) != 0);
        end
    end

    task automatic stop_run();
        error_count++;
        $display("Errors found");
        $fatal(1, "stopping at the first mismatch");
    endtask

    task automatic check_value(string what, logic [31:0] expected, logic [31:0] actual);
        assert (expected === actual) else begin
            $display("FAILED %s %s expected %h actual %h", test_name, what, expected, actual);
            stop_run();
        end
    endtask

    task automatic check_true(logic cond, string what);
        assert (cond) else begin
            $display("%s: %s", test_name, what);
            stop_run();
        end
    endtask

    // output side of the model, sampled away from the clock edge
    always @(negedge clk) begin
        stream_pkg::src_t  s;
        stream_pkg::beat_t want;
        if (!rst && out_valid && out_ready) begin
            s = out_beat.src;
            if (!in_pkt) begin
                check_true(!(forbid2 && s == 2), "a packet from masked port 2 started");
                start_log.push_back(s);
                cur_src = s;
                in_pkt  = 1'b1;
            end
            check_value("src inside packet", cur_src, s);
            check_true(src_q[s].size() > 0, $sformatf("beat from port %0d with none pending", s));
            want = src_q[s].pop_front();
            check_value("data", want.data, out_beat.data);
            check_value("last", want.last, out_beat.last);
            if (out_beat.last) begin
                in_pkt = 1'b0;
                done_count[s]++;
            end
        end
    end

    // one APB transfer, setup then access
    task automatic apb_xfer(input logic write, input regs_pkg::paddr_t addr,
                            input regs_pkg::pdata_t wdata, output regs_pkg::pdata_t rdata);
        apb_req = '{psel: 1'b1, penable: 1'b0, pwrite: write, paddr: addr, pwdata: wdata};
        @(posedge clk);
        #DRIVE_DELAY;
        apb_req.penable = 1'b1;
        @(negedge clk);
        rdata = prdata;
        // no wait states on this bus
        check_value("pready", 1, pready);
        @(posedge clk);
        #DRIVE_DELAY;
        apb_req = '0;
    endtask

    task automatic write_ctrl(regs_pkg::pdata_t value);
        regs_pkg::pdata_t rd;
        apb_xfer(1'b1, regs_pkg::ADDR_CTRL, value, rd);
        apb_xfer(1'b0, regs_pkg::ADDR_CTRL, '0, rd);
        check_value("ctrl readback", value, rd);
    endtask

    task automatic check_counters();
        regs_pkg::pdata_t rd;
        for (int i = 0; i < NUM_PORTS; i++) begin
            apb_xfer(1'b0, regs_pkg::ADDR_COUNT0 + regs_pkg::paddr_t'(i * 4), '0, rd);
            check_value($sformatf("count %0d", i), done_count[i] % 65536, rd);
        end
    endtask

    task automatic add_packets(logic [NUM_PORTS-1:0] ports, int count);
        for (int i = 0; i < NUM_PORTS; i++) begin
            if (ports[i]) pkt_target[i] += count;
        end
    endtask

    // until every listed port has delivered all its packets
    task automatic wait_done(logic [NUM_PORTS-1:0] ports);
        logic busy;
        busy = 1'b1;
        while (busy) begin
            @(posedge clk);
            busy = 1'b0;
            for (int i = 0; i < NUM_PORTS; i++) begin
                if (ports[i] && done_count[i] != pkt_target[i]) busy = 1'b1;
            end
        end
        #DRIVE_DELAY;
    endtask

    initial begin
        int held;
        void'($urandom(RAND_SEED));
        apb_req     = '0;
        gap_max     = 6;
        error_count = 0;
        sink_stall  = 1'b0;
        forbid2     = 1'b0;
        in_pkt      = 1'b0;
        cur_src     = '0;
        test_name   = "reset";
        for (int i = 0; i < NUM_PORTS; i++) begin
            pkt_target[i] = 0;
            done_count[i] = 0;
        end
        wait (rst === 1'b0);
        @(posedge clk);
        #DRIVE_DELAY;

        test_name = "integrity";
        add_packets(4'b1111, RANDOM_PKTS);
        wait_done(4'b1111);
        check_counters();

        // port 2 is idle when it gets masked
        test_name = "enable_mask";
        write_ctrl(32'h0000_000b);
        held    = done_count[2];
        forbid2 = 1'b1;
        add_packets(4'b1111, MASK_PKTS);
        wait_done(4'b1011);
        check_value("port 2 packets while masked", held, done_count[2]);
        forbid2 = 1'b0;
        write_ctrl(32'h0000_000f);
        wait_done(4'b1111);
        check_counters();

        test_name  = "fixed_priority";
        gap_max    = 0;
        sink_stall = 1'b1;
        start_log.delete();
        add_packets(4'b1010, 1);
        repeat (10) @(posedge clk);
        #DRIVE_DELAY;
        sink_stall = 1'b0;
        wait_done(4'b1111);
        check_value("first source", 1, start_log[0]);

        test_name = "round_robin";
        write_ctrl(32'h0000_010f);
        start_log.delete();
        add_packets(4'b1111, RR_PKTS);
        wait_done(4'b1111);
        check_value("packets", NUM_PORTS * RR_PKTS, start_log.size());
        for (int i = 1; i < start_log.size(); i++) begin
            check_value("next source", (int'(start_log[i-1]) + 1) % NUM_PORTS, start_log[i]);
        end
        check_counters();

        if (error_count == 0) begin
            $display("No errors");
        end else begin
            $display("Errors found");
        end
        $finish;
    end

    initial begin
        repeat (TIMEOUT_CYCLES) @(posedge clk);
        $display("timeout after %0d cycles in %s, packets stopped moving", TIMEOUT_CYCLES,
                 test_name);
        $display("Errors found");
        $fatal(1, "watchdog expired");
    end

endmodule

/* vlog.f */
stream_pkg.sv
regs_pkg.sv
packet_arbiter.sv
stream_arb_mux.sv
stream_skid_buffer.sv
mux_regs.sv
arb_mux_top.sv
tb_clock_gen.sv
arb_mux_assertions.sv
arb_mux_tb.sv

/* run_sim.sh */
#!/bin/sh
# build the testbench with Verilator, run it and look for the pass message in the log
cd "$(dirname "$0")" || exit 1
LOG=sim.log

verilator --binary --timing --assert -Wno-fatal --top-module arb_mux_tb \
    -f vlog.f -o arb_mux_sim
build_status=$?
if [ $build_status -ne 0 ]; then
    echo "verilator build failed with status $build_status"
    exit 1
fi

./obj_dir/arb_mux_sim > "$LOG" 2>&1
sim_status=$?
cat "$LOG"
if [ $sim_status -ne 0 ]; then
    echo "simulation exited with status $sim_status"
fi

if grep -qx "No errors" "$LOG"; then
    echo "simulation passed"
    exit 0
fi
echo "simulation failed, see $LOG"
exit 1
